/* tx_hrdrst.f */
+incdir+.
tx_hrdrst_pkg.sv
tx_hrdrst_status_sync.sv
tx_hrdrst_seq_fsm.sv
tx_hrdrst_out_ctl.sv
tx_hrdrst_top.sv
tb_tx_hrdrst.sv

/* run_sim.sh */
#!/bin/sh
# build with verilator, then run and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f tx_hrdrst.f --top-module tb_tx_hrdrst \
  -o sim_tx_hrdrst &&
out=$(./obj_dir/sim_tx_hrdrst) ; echo "$out" ;
echo "$out" | grep -q "SIMULATION PASSED" || exit 1

/* tb_tx_hrdrst_util.svh */
//**************************************************************************
// testbench helpers, included inside tb_tx_hrdrst after its signal list
//**************************************************************************
`ifndef TB_TX_HRDRST_UTIL_SVH
`define TB_TX_HRDRST_UTIL_SVH

// codes of the outputs that the wait task can poll
localparam int sig_aib_dcd_req  = 0;
localparam int sig_aib_lock_req = 1;
localparam int sig_dcd_done     = 2;
localparam int sig_lock         = 3;
localparam int sig_xfer_en      = 4;

int err_count = 0;
int tests_run = 0;
int tests_failed = 0;
int err_at_start = 0;
logic [31:0] lfsr_q = lfsr_seed;

// count a failed check and report it with the time
task automatic flag_error(input string msg);
  err_count++;
  $display("FAILED at %0t: %s", $time, msg);
endtask

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one lfsr step per bit taken
task automatic rand_bits(input int n, output logic [31:0] v);
  v = '0;
  for (int i = 0; i < n; i++)
  begin
    lfsr_q = lfsr_step(lfsr_q);
    v = {v[30:0], lfsr_q[0]};
  end
endtask

function automatic logic probe(input int sel);
  case (sel)
    sig_aib_dcd_req:  return aib_tx_dcd_cal_req;
    sig_aib_lock_req: return aib_tx_dll_lock_req;
    sig_dcd_done:     return hrdrst_tx_dcd_cal_done;
    sig_lock:         return hrdrst_tx_dll_lock;
    sig_xfer_en:      return hrdrst_tx_transfer_en;
    default:          return 1'b0;
  endcase
endfunction

// poll an output on each rising edge, give up after wait_limit cycles
task automatic wait_level(input int sel, input logic val, input string what);
  int n;
  n = 0;
  while ((probe(sel) !== val) && (n < wait_limit))
  begin
    @(posedge clk);
    n++;
  end
  if (probe(sel) !== val)
  begin
    $display("timeout at %0t: %s never reached %0b", $time, what, val);
    err_count++;
  end
endtask

task automatic idle(input int n);
  repeat (n) @(posedge clk);
endtask

// random gap of 1 to 8 cycles between responder steps
task automatic rand_idle();
  logic [31:0] v;
  rand_bits(3, v);
  idle(int'(v[2:0]) + 1);
endtask

task automatic start_test();
  err_at_start = err_count;
  tests_run++;
endtask

task automatic end_test(input string name);
  if (err_count == err_at_start)
  begin
    $display("test %s: ok", name);
  end
  else
  begin
    $display("test %s: %0d errors", name, err_count - err_at_start);
    tests_failed++;
  end
endtask

`endif

/* tb_tx_hrdrst.sv */
//**************************************************************************
// testbench for tx_hrdrst_top, checks are concurrent assertions below
//**************************************************************************
`default_nettype none

module tb_tx_hrdrst;

  localparam int clk_period = 10;
  localparam int wait_limit = 200;
  localparam logic [31:0] lfsr_seed = 32'h8923_be36;

  logic clk = 1'b0;
  logic tx_reset_hrdrst_rx_osc_clk_rst_n;
  logic dcd_cal_done;
  logic dll_lock;
  logic align_done;
  logic fifo_ready;
  logic bond_ds_dcd_cal_done;
  logic bond_us_dcd_cal_done;
  logic bond_ds_dll_lock;
  logic bond_us_dll_lock;
  logic ds_last_chnl;
  logic us_last_chnl;
  logic bonding_dft_in_en;
  logic bonding_dft_in_value;
  logic indv;
  logic dll_lock_bypass;
  logic pld_dll_lock_req;
  logic fabric_dcd_cal_done;
  logic dcd_cal_done_bypass;
  logic align_bypass;
  logic user_ctl_en;
  logic rst_sm_dis;
  logic osc_transfer_alive;
  logic sr_dcd_cal_req;
  logic sr_dll_lock_req;
  logic sr_fifo_srst;
  tx_hrdrst_pkg::master_sel_t master_sel;
  wire aib_tx_dcd_cal_req;
  wire aib_tx_dll_lock_req;
  wire tx_fifo_srst;
  wire hrdrst_tx_dcd_cal_done;
  wire hrdrst_tx_dll_lock;
  wire hrdrst_tx_transfer_en;
  wire state_chg_toggle;
  // windows in which the per-test assertions apply
  logic order_chk;
  logic nbr_chk;
  logic slave_chk;
  logic [31:0] rv;

  `include "tb_tx_hrdrst_util.svh"

  always #(clk_period / 2) clk = ~clk;

  tx_hrdrst_top u_dut (
    .tx_clock_hrdrst_rx_osc_clk(clk),
    .*
  );

  //************************************************************************
  // checking assertions
  //************************************************************************
  a_xfer_lock: assert property (@(posedge clk) disable iff (!tx_reset_hrdrst_rx_osc_clk_rst_n)
    hrdrst_tx_transfer_en |-> hrdrst_tx_dll_lock)
    else flag_error("transfer_en without lock");
  // master fifo reset is released exactly with lock
  a_master_srst: assert property (@(posedge clk) disable iff (!tx_reset_hrdrst_rx_osc_clk_rst_n)
    (master_sel == 2'b00) && !user_ctl_en |-> tx_fifo_srst == !hrdrst_tx_dll_lock)
    else flag_error("master fifo reset vs lock");
  a_order_dcd: assert property (@(posedge clk) disable iff (!tx_reset_hrdrst_rx_osc_clk_rst_n)
    order_chk && $rose(hrdrst_tx_dcd_cal_done) |-> aib_tx_dcd_cal_req)
    else flag_error("dcd done before dcd request");
  // lock request leaves the sync 3 samples after dcd done drops
  a_order_lreq: assert property (@(posedge clk) disable iff (!tx_reset_hrdrst_rx_osc_clk_rst_n)
    order_chk && $rose(aib_tx_dll_lock_req) |-> $past(hrdrst_tx_dcd_cal_done, 3))
    else flag_error("lock request before dcd done");
  a_order_lock: assert property (@(posedge clk) disable iff (!tx_reset_hrdrst_rx_osc_clk_rst_n)
    order_chk && $rose(hrdrst_tx_dll_lock) |-> aib_tx_dll_lock_req && !tx_fifo_srst)
    else flag_error("lock before lock request");
  // registered outputs only move on a state change, which flips the toggle
  a_state_toggle: assert property (@(posedge clk) disable iff (!tx_reset_hrdrst_rx_osc_clk_rst_n)
    $changed(hrdrst_tx_dcd_cal_done) || $changed(hrdrst_tx_dll_lock) ||
    $changed(hrdrst_tx_transfer_en) |-> $changed(state_chg_toggle))
    else flag_error("state change without toggle");
  a_nbr_block: assert property (@(posedge clk) disable iff (!tx_reset_hrdrst_rx_osc_clk_rst_n)
    nbr_chk |-> aib_tx_dcd_cal_req && !hrdrst_tx_dcd_cal_done)
    else flag_error("neighbor not done ignored");
  // two cycles of hold are enough to clear transfer_en
  a_hold_idle: assert property (@(posedge clk) disable iff (!tx_reset_hrdrst_rx_osc_clk_rst_n)
    $past(!osc_transfer_alive || rst_sm_dis || user_ctl_en, 1) &&
    $past(!osc_transfer_alive || rst_sm_dis || user_ctl_en, 2) |-> !hrdrst_tx_transfer_en)
    else flag_error("transfer_en under hold");
  a_user_srst: assert property (@(posedge clk) disable iff (!tx_reset_hrdrst_rx_osc_clk_rst_n)
    user_ctl_en |-> tx_fifo_srst == sr_fifo_srst)
    else flag_error("fifo reset not from sr");
  a_user_req: assert property (@(posedge clk) disable iff (!tx_reset_hrdrst_rx_osc_clk_rst_n)
    $past(user_ctl_en, 2) |-> aib_tx_dcd_cal_req == $past(sr_dcd_cal_req, 2) &&
    aib_tx_dll_lock_req == $past(sr_dll_lock_req, 2))
    else flag_error("requests not from sr");
  a_slave_srst: assert property (@(posedge clk) disable iff (!tx_reset_hrdrst_rx_osc_clk_rst_n)
    slave_chk |-> tx_fifo_srst == !($past(dll_lock, 2) || dll_lock_bypass))
    else flag_error("slave fifo reset vs lock");
  a_bonded_slave: assert property (@(posedge clk) disable iff (!tx_reset_hrdrst_rx_osc_clk_rst_n)
    (master_sel != 2'b00) && !indv && !user_ctl_en |-> !tx_fifo_srst)
    else flag_error("bonded slave fifo reset high");

  //************************************************************************
  // responder steps
  //************************************************************************
  task automatic respond_dcd();
    wait_level(sig_aib_dcd_req, 1'b1, "aib dcd request");
    rand_idle();
    dcd_cal_done <= 1'b1;
  endtask

  task automatic respond_rest();
    wait_level(sig_dcd_done, 1'b1, "dcd done");
    rand_idle();
    fabric_dcd_cal_done <= 1'b1;
    wait_level(sig_aib_lock_req, 1'b1, "aib lock request");
    rand_idle();
    dll_lock <= 1'b1;
    wait_level(sig_lock, 1'b1, "dll lock");
    rand_idle();
    align_done <= 1'b1;
    fifo_ready <= 1'b1;
    wait_level(sig_xfer_en, 1'b1, "transfer_en");
  endtask

  // request withdrawn and status cleared so the next run can start
  task automatic teardown();
    @(posedge clk);
    pld_dll_lock_req <= 1'b0;
    wait_level(sig_xfer_en, 1'b0, "transfer_en low");
    wait_level(sig_aib_dcd_req, 1'b0, "aib dcd request low");
    wait_level(sig_aib_lock_req, 1'b0, "aib lock request low");
    dcd_cal_done <= 1'b0;
    dll_lock <= 1'b0;
    align_done <= 1'b0;
    fifo_ready <= 1'b0;
    fabric_dcd_cal_done <= 1'b0;
    idle(4);
  endtask

  //************************************************************************
  // stimulus
  //************************************************************************
  initial
  begin
    tx_reset_hrdrst_rx_osc_clk_rst_n <= 1'b0;
    {dcd_cal_done, dll_lock, align_done, fifo_ready} <= '0;
    {bond_ds_dcd_cal_done, bond_us_dcd_cal_done, bond_ds_dll_lock, bond_us_dll_lock} <= '1;
    {ds_last_chnl, us_last_chnl, bonding_dft_in_en, bonding_dft_in_value} <= '0;
    {indv, dll_lock_bypass, pld_dll_lock_req, fabric_dcd_cal_done} <= '0;
    {dcd_cal_done_bypass, align_bypass, user_ctl_en, rst_sm_dis} <= '0;
    osc_transfer_alive <= 1'b1;
    {sr_dcd_cal_req, sr_dll_lock_req, sr_fifo_srst} <= '0;
    master_sel <= 2'b00;
    {order_chk, nbr_chk, slave_chk} <= '0;
    idle(4);
    tx_reset_hrdrst_rx_osc_clk_rst_n <= 1'b1;
    idle(2);

    start_test();
    order_chk <= 1'b1;
    pld_dll_lock_req <= 1'b1;
    respond_dcd();
    respond_rest();
    idle(4);
    order_chk <= 1'b0;
    teardown();
    end_test("master bring-up");

    start_test();
    {dcd_cal_done_bypass, dll_lock_bypass, align_bypass} <= 3'b111;
    pld_dll_lock_req <= 1'b1;
    wait_level(sig_dcd_done, 1'b1, "dcd done by bypass");
    fabric_dcd_cal_done <= 1'b1;
    fifo_ready <= 1'b1;
    wait_level(sig_xfer_en, 1'b1, "transfer_en by bypass");
    teardown();
    {dcd_cal_done_bypass, dll_lock_bypass, align_bypass} <= 3'b000;
    end_test("bypass flags");

    start_test();
    // downstream neighbor not done, released by its last-channel flag
    bond_ds_dcd_cal_done <= 1'b0;
    pld_dll_lock_req <= 1'b1;
    respond_dcd();
    idle(3);
    nbr_chk <= 1'b1;
    idle(20);
    nbr_chk <= 1'b0;
    ds_last_chnl <= 1'b1;
    respond_rest();
    teardown();
    // now the dft value stands in for both neighbors
    ds_last_chnl <= 1'b0;
    bonding_dft_in_en <= 1'b1;
    pld_dll_lock_req <= 1'b1;
    respond_dcd();
    idle(3);
    nbr_chk <= 1'b1;
    idle(20);
    nbr_chk <= 1'b0;
    bonding_dft_in_value <= 1'b1;
    respond_rest();
    teardown();
    {bonding_dft_in_en, bonding_dft_in_value, bond_ds_dcd_cal_done} <= 3'b001;
    end_test("bonded merge");

    start_test();
    pld_dll_lock_req <= 1'b1;
    respond_dcd();
    respond_rest();
    osc_transfer_alive <= 1'b0;
    wait_level(sig_xfer_en, 1'b0, "transfer_en after link loss");
    wait_level(sig_aib_dcd_req, 1'b0, "dcd request after link loss");
    wait_level(sig_aib_lock_req, 1'b0, "lock request after link loss");
    osc_transfer_alive <= 1'b1;
    teardown();
    end_test("return to idle");

    start_test();
    user_ctl_en <= 1'b1;
    pld_dll_lock_req <= 1'b1;
    repeat (40)
    begin
      rand_bits(3, rv);
      {sr_dcd_cal_req, sr_dll_lock_req, sr_fifo_srst} <= rv[2:0];
      @(posedge clk);
    end
    // request goes with the override so the sequencer stays idle
    {user_ctl_en, pld_dll_lock_req, sr_dcd_cal_req, sr_dll_lock_req, sr_fifo_srst} <= 5'b00000;
    teardown();
    end_test("user control");

    start_test();
    master_sel <= 2'b01;
    indv <= 1'b1;
    // neighbor lock missing, an individual slave looks at its own dll only
    bond_ds_dll_lock <= 1'b0;
    idle(3);
    slave_chk <= 1'b1;
    repeat (40)
    begin
      rand_bits(2, rv);
      {dll_lock, dll_lock_bypass} <= rv[1:0];
      @(posedge clk);
    end
    slave_chk <= 1'b0;
    @(posedge clk);
    indv <= 1'b0;
    idle(20);
    {master_sel, dll_lock, dll_lock_bypass} <= 4'b0000;
    bond_ds_dll_lock <= 1'b1;
    idle(4);
    end_test("slave fifo reset");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0)
    begin
      $display("SIMULATION PASSED");
    end
    else
    begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // whole run limit in case a wait loop is never reached
  initial
  begin
    #(200000);
    $display("run limit expired before the tests finished");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* tx_hrdrst_top.sv */
//**************************************************************************
// tx hard-reset sequencer top, single rx osc clock domain
// reset is synchronous to tx_clock_hrdrst_rx_osc_clk and active low
//**************************************************************************
`default_nettype none

module tx_hrdrst_top (
  input  logic                        tx_clock_hrdrst_rx_osc_clk,
  input  logic                        tx_reset_hrdrst_rx_osc_clk_rst_n,
  input  logic                        dcd_cal_done,
  input  logic                        dll_lock,
  input  logic                        bond_ds_dcd_cal_done,
  input  logic                        bond_us_dcd_cal_done,
  input  logic                        bond_ds_dll_lock,
  input  logic                        bond_us_dll_lock,
  input  logic                        ds_last_chnl,
  input  logic                        us_last_chnl,
  input  logic                        bonding_dft_in_en,
  input  logic                        bonding_dft_in_value,
  input  logic                        indv,
  input  tx_hrdrst_pkg::master_sel_t  master_sel,
  input  logic                        dll_lock_bypass,
  input  logic                        align_done,
  input  logic                        fifo_ready,
  input  logic                        pld_dll_lock_req,
  input  logic                        fabric_dcd_cal_done,
  input  logic                        dcd_cal_done_bypass,
  input  logic                        align_bypass,
  input  logic                        user_ctl_en,
  input  logic                        rst_sm_dis,
  input  logic                        osc_transfer_alive,
  input  logic                        sr_dcd_cal_req,
  input  logic                        sr_dll_lock_req,
  input  logic                        sr_fifo_srst,
  output logic                        aib_tx_dcd_cal_req,
  output logic                        aib_tx_dll_lock_req,
  output logic                        tx_fifo_srst,
  output logic                        hrdrst_tx_dcd_cal_done,
  output logic                        hrdrst_tx_dll_lock,
  output logic                        hrdrst_tx_transfer_en,
  output logic                        state_chg_toggle
);

  //************************************************************************
  // stage to stage nets
  //************************************************************************

  // synchronized status into the sequencer
  wire sync_dcd_cal_done;
  wire sync_dll_lock;
  wire dll_lock_ok;
  wire sync_align_done;
  wire sync_fifo_ready;
  // sequencer requests before the output sync
  wire seq_dcd_cal_req;
  wire seq_dll_lock_req;
  wire seq_fifo_srst;
  // idle force back from the override logic
  wire seq_hold;

  // port names match the nets one to one
  tx_hrdrst_status_sync u_status_sync (.*);

  tx_hrdrst_seq_fsm u_seq_fsm (.*);

  tx_hrdrst_out_ctl u_out_ctl (.*);

endmodule

`default_nettype wire

/* tx_hrdrst_out_ctl.sv */
//**************************************************************************
// user override, fifo soft reset select and request output synchronizers
// a non-individual slave keeps its fifo soft reset low
//**************************************************************************
`default_nettype none

module tx_hrdrst_out_ctl (
  input  logic                        tx_clock_hrdrst_rx_osc_clk,
  input  logic                        tx_reset_hrdrst_rx_osc_clk_rst_n,
  input  logic                        user_ctl_en,
  input  logic                        rst_sm_dis,
  input  logic                        osc_transfer_alive,
  input  logic                        sr_dcd_cal_req,
  input  logic                        sr_dll_lock_req,
  input  logic                        sr_fifo_srst,
  input  tx_hrdrst_pkg::master_sel_t  master_sel,
  input  logic                        indv,
  input  logic                        dll_lock_ok,
  input  logic                        seq_dcd_cal_req,
  input  logic                        seq_dll_lock_req,
  input  logic                        seq_fifo_srst,
  output logic                        seq_hold,
  output logic                        aib_tx_dcd_cal_req,
  output logic                        aib_tx_dll_lock_req,
  output logic                        tx_fifo_srst
);

  // bit 0 dcd request, bit 1 lock request
  logic [1:0] req_sel;
  logic [1:0] req_pipe [tx_hrdrst_pkg::sync_stages];

  // sequencer parked while the osc link is down or software owns the outputs
  assign seq_hold = ~osc_transfer_alive | rst_sm_dis | user_ctl_en;

  //************************************************************************
  // request source and output synchronizer
  //************************************************************************
  assign req_sel = user_ctl_en ? {sr_dll_lock_req, sr_dcd_cal_req}
                               : {seq_dll_lock_req, seq_dcd_cal_req};

  always_ff @(posedge tx_clock_hrdrst_rx_osc_clk)
  begin
    if (!tx_reset_hrdrst_rx_osc_clk_rst_n)
    begin
      for (int i = 0; i < tx_hrdrst_pkg::sync_stages; i++)
      begin
        req_pipe[i] <= '0;
      end
    end
    else
    begin
      req_pipe[0] <= req_sel;
      for (int i = 1; i < tx_hrdrst_pkg::sync_stages; i++)
      begin
        req_pipe[i] <= req_pipe[i-1];
      end
    end
  end

  assign aib_tx_dcd_cal_req  = req_pipe[tx_hrdrst_pkg::sync_stages-1][0];
  assign aib_tx_dll_lock_req = req_pipe[tx_hrdrst_pkg::sync_stages-1][1];

  //************************************************************************
  // fifo soft reset select
  //************************************************************************
  always_comb
  begin
    if (user_ctl_en)
    begin
      tx_fifo_srst = sr_fifo_srst;
    end
    else if ((master_sel != tx_hrdrst_pkg::role_master) && indv)
    begin
      // individual slave releases on its own lock
      tx_fifo_srst = ~dll_lock_ok;
    end
    else if (master_sel == tx_hrdrst_pkg::role_master)
    begin
      tx_fifo_srst = seq_fifo_srst;
    end
    else
    begin
      tx_fifo_srst = 1'b0;
    end
  end

  // sequencer order survives the sync, user values are exempt
  a_lock_after_dcd: assert property (
    @(posedge tx_clock_hrdrst_rx_osc_clk) disable iff (!tx_reset_hrdrst_rx_osc_clk_rst_n)
    $rose(aib_tx_dll_lock_req) |->
      aib_tx_dcd_cal_req || $past(user_ctl_en, tx_hrdrst_pkg::sync_stages))
    else $error("lock request rose without a dcd request");

endmodule

`default_nettype wire

/* tx_hrdrst_seq_fsm.sv */
//**************************************************************************
// tx reset sequencer with registered outputs one cycle behind the state
// seq_hold forces the idle state and must come from the same clock domain
//**************************************************************************
`default_nettype none

module tx_hrdrst_seq_fsm (
  input  logic tx_clock_hrdrst_rx_osc_clk,
  input  logic tx_reset_hrdrst_rx_osc_clk_rst_n,
  input  logic seq_hold,
  input  logic pld_dll_lock_req,
  input  logic fabric_dcd_cal_done,
  input  logic dcd_cal_done_bypass,
  input  logic align_bypass,
  input  logic sync_dcd_cal_done,
  input  logic sync_dll_lock,
  input  logic dll_lock_ok,
  input  logic sync_align_done,
  input  logic sync_fifo_ready,
  output logic seq_dcd_cal_req,
  output logic seq_dll_lock_req,
  output logic seq_fifo_srst,
  output logic hrdrst_tx_dcd_cal_done,
  output logic hrdrst_tx_dll_lock,
  output logic hrdrst_tx_transfer_en,
  output logic state_chg_toggle
);

  tx_hrdrst_pkg::seq_state_t state_q;
  tx_hrdrst_pkg::seq_state_t state_nxt;
  // state one cycle back, for change detection
  tx_hrdrst_pkg::seq_state_t state_prev;

  // output decode of the current state
  logic dcd_req_nxt;
  logic lock_req_nxt;
  logic dcd_done_nxt;
  logic lock_nxt;
  logic fifo_srst_nxt;
  logic xfer_en_nxt;

  //************************************************************************
  // state register and progress toggle
  //************************************************************************
  always_ff @(posedge tx_clock_hrdrst_rx_osc_clk)
  begin
    if (!tx_reset_hrdrst_rx_osc_clk_rst_n)
    begin
      state_q          <= tx_hrdrst_pkg::wait_transfer_req;
      state_prev       <= tx_hrdrst_pkg::wait_transfer_req;
      state_chg_toggle <= 1'b0;
    end
    else
    begin
      // hold restarts the sequence from idle
      if (seq_hold)
      begin
        state_q <= tx_hrdrst_pkg::wait_transfer_req;
      end
      else
      begin
        state_q <= state_nxt;
      end
      state_prev <= state_q;
      if (state_q != state_prev)
      begin
        state_chg_toggle <= ~state_chg_toggle;
      end
    end
  end

  //************************************************************************
  // next state and output decode
  //************************************************************************
  always_comb
  begin
    state_nxt     = state_q;
    dcd_req_nxt   = 1'b0;
    lock_req_nxt  = 1'b0;
    dcd_done_nxt  = 1'b0;
    lock_nxt      = 1'b0;
    fifo_srst_nxt = 1'b1;
    xfer_en_nxt   = 1'b0;
    case (state_q)
      tx_hrdrst_pkg::wait_transfer_req:
      begin
        // stale done or lock from a previous run blocks the start
        if (pld_dll_lock_req && !sync_dcd_cal_done && !sync_dll_lock)
        begin
          state_nxt = tx_hrdrst_pkg::send_dcd_cal_req;
        end
      end
      tx_hrdrst_pkg::send_dcd_cal_req:
      begin
        dcd_req_nxt = 1'b1;
        if (sync_dcd_cal_done || dcd_cal_done_bypass)
        begin
          state_nxt = tx_hrdrst_pkg::wait_remote_dcd_cal_done;
        end
      end
      tx_hrdrst_pkg::wait_remote_dcd_cal_done:
      begin
        dcd_req_nxt  = 1'b1;
        dcd_done_nxt = 1'b1;
        if (fabric_dcd_cal_done)
        begin
          state_nxt = tx_hrdrst_pkg::send_dll_lock_req;
        end
      end
      tx_hrdrst_pkg::send_dll_lock_req:
      begin
        dcd_req_nxt  = 1'b1;
        lock_req_nxt = 1'b1;
        if (dll_lock_ok)
        begin
          state_nxt = tx_hrdrst_pkg::wait_align_done;
        end
      end
      tx_hrdrst_pkg::wait_align_done:
      begin
        dcd_req_nxt   = 1'b1;
        lock_req_nxt  = 1'b1;
        lock_nxt      = 1'b1;
        fifo_srst_nxt = 1'b0;
        if ((sync_align_done || align_bypass) && sync_fifo_ready)
        begin
          state_nxt = tx_hrdrst_pkg::transfer_en;
        end
      end
      tx_hrdrst_pkg::transfer_en:
      begin
        dcd_req_nxt   = 1'b1;
        lock_req_nxt  = 1'b1;
        lock_nxt      = 1'b1;
        fifo_srst_nxt = 1'b0;
        xfer_en_nxt   = 1'b1;
        // request withdrawn so tear down
        if (!pld_dll_lock_req)
        begin
          state_nxt = tx_hrdrst_pkg::wait_transfer_req;
        end
      end
      default:
      begin
        state_nxt = tx_hrdrst_pkg::wait_transfer_req;
      end
    endcase
  end

  //************************************************************************
  // registered outputs
  //************************************************************************
  always_ff @(posedge tx_clock_hrdrst_rx_osc_clk)
  begin
    if (!tx_reset_hrdrst_rx_osc_clk_rst_n)
    begin
      seq_dcd_cal_req        <= 1'b0;
      seq_dll_lock_req       <= 1'b0;
      // fifo held in reset until lock
      seq_fifo_srst          <= 1'b1;
      hrdrst_tx_dcd_cal_done <= 1'b0;
      hrdrst_tx_dll_lock     <= 1'b0;
      hrdrst_tx_transfer_en  <= 1'b0;
    end
    else
    begin
      seq_dcd_cal_req        <= dcd_req_nxt;
      seq_dll_lock_req       <= lock_req_nxt;
      seq_fifo_srst          <= fifo_srst_nxt;
      hrdrst_tx_dcd_cal_done <= dcd_done_nxt;
      hrdrst_tx_dll_lock     <= lock_nxt;
      hrdrst_tx_transfer_en  <= xfer_en_nxt;
    end
  end

  // lock was already up the cycle before and stays up with transfer_en
  a_xfer_needs_lock: assert property (
    @(posedge tx_clock_hrdrst_rx_osc_clk) disable iff (!tx_reset_hrdrst_rx_osc_clk_rst_n)
    hrdrst_tx_transfer_en |-> hrdrst_tx_dll_lock && $past(hrdrst_tx_dll_lock))
    else $error("transfer_en without dll lock");

  a_state_legal: assert property (
    @(posedge tx_clock_hrdrst_rx_osc_clk) disable iff (!tx_reset_hrdrst_rx_osc_clk_rst_n)
    !$isunknown(state_q) && (state_q <= tx_hrdrst_pkg::transfer_en))
    else $error("sequencer state outside the defined set");

endmodule

`default_nettype wire

/* tx_hrdrst_status_sync.sv */
//**************************************************************************
// bonded status merge and two-flop sync into the rx osc clock domain
// status inputs are levels that are held for longer than sync_stages cycles
//**************************************************************************
`default_nettype none

module tx_hrdrst_status_sync (
  input  logic                        tx_clock_hrdrst_rx_osc_clk,
  input  logic                        tx_reset_hrdrst_rx_osc_clk_rst_n,
  input  logic                        dcd_cal_done,
  input  logic                        dll_lock,
  input  logic                        bond_ds_dcd_cal_done,
  input  logic                        bond_us_dcd_cal_done,
  input  logic                        bond_ds_dll_lock,
  input  logic                        bond_us_dll_lock,
  input  logic                        ds_last_chnl,
  input  logic                        us_last_chnl,
  input  logic                        bonding_dft_in_en,
  input  logic                        bonding_dft_in_value,
  input  logic                        indv,
  input  tx_hrdrst_pkg::master_sel_t  master_sel,
  input  logic                        dll_lock_bypass,
  input  logic                        align_done,
  input  logic                        fifo_ready,
  output logic                        sync_dcd_cal_done,
  output logic                        sync_dll_lock,
  output logic                        dll_lock_ok,
  output logic                        sync_align_done,
  output logic                        sync_fifo_ready
);

  // neighbor status after dft override and last-channel forcing
  logic ds_dcd_nbr;
  logic us_dcd_nbr;
  logic ds_lock_nbr;
  logic us_lock_nbr;
  // slave channel running its own fifo and lock
  logic indv_slave;
  logic dcd_merged;
  logic lock_merged;
  // bit 0 dcd done, bit 1 lock, bit 2 align, bit 3 fifo ready
  logic [3:0] sync_in;
  logic [3:0] sync_pipe [tx_hrdrst_pkg::sync_stages];

  //************************************************************************
  // bonded merge
  //************************************************************************

  // dft value replaces the neighbor, an edge channel has no neighbor to wait on
  assign ds_dcd_nbr  = ds_last_chnl |
                       (bonding_dft_in_en ? bonding_dft_in_value : bond_ds_dcd_cal_done);
  assign us_dcd_nbr  = us_last_chnl |
                       (bonding_dft_in_en ? bonding_dft_in_value : bond_us_dcd_cal_done);
  assign ds_lock_nbr = ds_last_chnl |
                       (bonding_dft_in_en ? bonding_dft_in_value : bond_ds_dll_lock);
  assign us_lock_nbr = us_last_chnl |
                       (bonding_dft_in_en ? bonding_dft_in_value : bond_us_dll_lock);

  assign indv_slave = (master_sel != tx_hrdrst_pkg::role_master) && indv;

  // dcd done always waits for the whole bonded group
  assign dcd_merged = dcd_cal_done & ds_dcd_nbr & us_dcd_nbr;

  // individual slave polls its own dll only
  assign lock_merged = indv_slave ? dll_lock : (dll_lock & ds_lock_nbr & us_lock_nbr);

  assign sync_in = {fifo_ready, align_done, lock_merged, dcd_merged};

  //************************************************************************
  // synchronizer flops
  //************************************************************************
  always_ff @(posedge tx_clock_hrdrst_rx_osc_clk)
  begin
    if (!tx_reset_hrdrst_rx_osc_clk_rst_n)
    begin
      for (int i = 0; i < tx_hrdrst_pkg::sync_stages; i++)
      begin
        sync_pipe[i] <= '0;
      end
    end
    else
    begin
      sync_pipe[0] <= sync_in;
      for (int i = 1; i < tx_hrdrst_pkg::sync_stages; i++)
      begin
        sync_pipe[i] <= sync_pipe[i-1];
      end
    end
  end

  assign sync_dcd_cal_done = sync_pipe[tx_hrdrst_pkg::sync_stages-1][0];
  assign sync_dll_lock     = sync_pipe[tx_hrdrst_pkg::sync_stages-1][1];
  assign sync_align_done   = sync_pipe[tx_hrdrst_pkg::sync_stages-1][2];
  assign sync_fifo_ready   = sync_pipe[tx_hrdrst_pkg::sync_stages-1][3];

  // bypass stands in for a lock that never comes
  assign dll_lock_ok = sync_dll_lock | dll_lock_bypass;

  // a known merged status comes out known after the crossing
  a_merge_known: assert property (
    @(posedge tx_clock_hrdrst_rx_osc_clk) disable iff (!tx_reset_hrdrst_rx_osc_clk_rst_n)
    !$isunknown({dcd_merged, lock_merged}) |-> ##(tx_hrdrst_pkg::sync_stages)
      !$isunknown({sync_dcd_cal_done, sync_dll_lock}))
    else $error("unknown dcd or lock status left the synchronizer");

  // same for the align and fifo ready path
  a_ready_known: assert property (
    @(posedge tx_clock_hrdrst_rx_osc_clk) disable iff (!tx_reset_hrdrst_rx_osc_clk_rst_n)
    !$isunknown({align_done, fifo_ready}) |-> ##(tx_hrdrst_pkg::sync_stages)
      !$isunknown({sync_align_done, sync_fifo_ready}))
    else $error("unknown align or fifo ready left the synchronizer");

endmodule

`default_nettype wire

/* tx_hrdrst_pkg.sv */
//**************************************************************************
// shared widths and codes for the tx hard-reset sequencer
// state codes are fixed and must stay inside seq_state_w bits
//**************************************************************************
`default_nettype none

package tx_hrdrst_pkg;

  // flop depth of every status and request synchronizer
  localparam int sync_stages = 2;

  // width of the sequencer state register
  localparam int seq_state_w = 3;

  // channel role as set by configuration
  typedef logic [1:0] master_sel_t;

  // role code of the channel that owns the bonded sequence
  localparam master_sel_t role_master = 2'b00;

  //************************************************************************
  // sequencer states in bring-up order
  //************************************************************************
  typedef enum logic [seq_state_w-1:0] {
    // idle until the lock request shows up
    wait_transfer_req        = 3'd0,
    send_dcd_cal_req         = 3'd1,
    // local dcd done and waiting on the fabric side
    wait_remote_dcd_cal_done = 3'd2,
    send_dll_lock_req        = 3'd3,
    wait_align_done          = 3'd4,
    // bring-up complete
    transfer_en              = 3'd5
  } seq_state_t;

endpackage

`default_nettype wire
